// File: rv32_core_pkg.sv
// ####################
// shared widths, opcodes, alu codes, instruction views and step structs
// ####################
package rv32_core_pkg;

    localparam int xlen       = 32;
    localparam int reg_addr_w = 5;
    localparam logic [xlen-1:0] reset_pc = 32'h0000_0000;

    localparam logic [6:0] opc_lui    = 7'b0110111;
    localparam logic [6:0] opc_op_imm = 7'b0010011;
    localparam logic [6:0] opc_op     = 7'b0110011;
    localparam logic [6:0] opc_load   = 7'b0000011;
    localparam logic [6:0] opc_store  = 7'b0100011;
    localparam logic [6:0] opc_branch = 7'b1100011;
    localparam logic [6:0] opc_jal    = 7'b1101111;

    localparam logic [1:0] kind_fetch = 2'd0; // memory request kinds
    localparam logic [1:0] kind_load  = 2'd1;
    localparam logic [1:0] kind_store = 2'd2;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_XOR,
        ALU_SRL, ALU_SRA, ALU_OR, ALU_AND, ALU_PASS_B
    } alu_op_t;

    typedef enum logic {MEM_BYTE, MEM_WORD} mem_size_t;

    typedef enum logic [2:0] {S_FETCH, S_DECODE, S_EXEC, S_MEM, S_WB} seq_state_t;

    typedef struct packed {
        logic [6:0] funct7; logic [4:0] rs2; logic [4:0] rs1;
        logic [2:0] funct3; logic [4:0] rd;  logic [6:0] opcode;
    } r_fmt_t;
    typedef struct packed {
        logic [11:0] imm; logic [4:0] rs1; logic [2:0] funct3;
        logic [4:0] rd;   logic [6:0] opcode;
    } i_fmt_t;
    typedef struct packed {
        logic [6:0] imm_hi; logic [4:0] rs2; logic [4:0] rs1;
        logic [2:0] funct3; logic [4:0] imm_lo; logic [6:0] opcode;
    } s_fmt_t;
    typedef struct packed {
        logic imm12; logic [5:0] imm10_5; logic [4:0] rs2; logic [4:0] rs1;
        logic [2:0] funct3; logic [3:0] imm4_1; logic imm11; logic [6:0] opcode;
    } b_fmt_t;
    typedef struct packed {
        logic [19:0] imm; logic [4:0] rd; logic [6:0] opcode;
    } u_fmt_t;
    typedef struct packed {
        logic imm20; logic [9:0] imm10_1; logic imm11; logic [7:0] imm19_12;
        logic [4:0] rd; logic [6:0] opcode;
    } j_fmt_t;

    typedef union packed {
        r_fmt_t r_fmt;
        i_fmt_t i_fmt;
        s_fmt_t s_fmt;
        b_fmt_t b_fmt;
        u_fmt_t u_fmt;
        j_fmt_t j_fmt;
    } inst_word_u;

    typedef struct packed {
        logic [reg_addr_w-1:0] rs1;
        logic [reg_addr_w-1:0] rs2;
        logic [reg_addr_w-1:0] rd;
        logic [xlen-1:0]       imm;           // already sign extended
        alu_op_t               alu_op;
        logic                  use_imm;       // operand b from imm
        logic                  reg_write;
        logic                  is_load;
        logic                  is_store;
        logic                  is_branch;
        logic                  is_jal;
        mem_size_t             mem_size;
        logic                  load_unsigned; // lbu
        logic [2:0]            branch_funct;  // funct3 of the branch
    } dec_t;

    typedef struct packed {
        logic [xlen-1:0] alu_result;
        logic            take_branch;
        logic [xlen-1:0] target;              // pc + imm
    } exec_t;

endpackage

// File: inst_decoder.sv
// ####################
// instruction decoder: control fields, alu op, immediates
// ####################
`timescale 1ns/1ns
module inst_decoder (
    input  rv32_core_pkg::inst_word_u inst,
    output rv32_core_pkg::dec_t       dec
);
    import rv32_core_pkg::*;

    logic [xlen-1:0] i_imm, s_imm, b_imm, u_imm, j_imm;
    logic [2:0]      f3;

    function automatic alu_op_t funct_to_alu(input logic [2:0] fn3, input logic f7_b5,
                                             input logic reg_form);
        case (fn3)
            3'b000:  funct_to_alu = (reg_form && f7_b5) ? ALU_SUB : ALU_ADD; // sub only r-type
            3'b001:  funct_to_alu = ALU_SLL;
            3'b010:  funct_to_alu = ALU_SLT;
            3'b100:  funct_to_alu = ALU_XOR;
            3'b101:  funct_to_alu = f7_b5 ? ALU_SRA : ALU_SRL;
            3'b110:  funct_to_alu = ALU_OR;
            3'b111:  funct_to_alu = ALU_AND;
            default: funct_to_alu = ALU_ADD;
        endcase
    endfunction

    assign f3    = inst.r_fmt.funct3;
    assign i_imm = {{20{inst.i_fmt.imm[11]}}, inst.i_fmt.imm};
    assign s_imm = {{20{inst.s_fmt.imm_hi[6]}}, inst.s_fmt.imm_hi, inst.s_fmt.imm_lo};
    assign b_imm = {{19{inst.b_fmt.imm12}}, inst.b_fmt.imm12, inst.b_fmt.imm11,
                    inst.b_fmt.imm10_5, inst.b_fmt.imm4_1, 1'b0};
    assign u_imm = {inst.u_fmt.imm, 12'b0};
    assign j_imm = {{11{inst.j_fmt.imm20}}, inst.j_fmt.imm20, inst.j_fmt.imm19_12,
                    inst.j_fmt.imm11, inst.j_fmt.imm10_1, 1'b0};

    always_comb
    begin
        dec              = '0;             // unknown opcode: all enables low
        dec.rs1          = inst.r_fmt.rs1;
        dec.rs2          = inst.r_fmt.rs2;
        dec.rd           = inst.r_fmt.rd;
        dec.alu_op       = ALU_ADD;
        dec.mem_size     = f3[1] ? MEM_WORD : MEM_BYTE;
        dec.branch_funct = f3;
        case (inst.r_fmt.opcode)
            opc_lui:
            begin
                dec.imm = u_imm; dec.alu_op = ALU_PASS_B;
                dec.use_imm = 1'b1; dec.reg_write = 1'b1;
            end
            opc_op_imm:
            begin
                dec.imm = i_imm; dec.use_imm = 1'b1;
                dec.alu_op    = funct_to_alu(f3, inst.r_fmt.funct7[5], 1'b0);
                dec.reg_write = (f3 != 3'b011);  // sltiu not supported
            end
            opc_op:
            begin
                dec.alu_op    = funct_to_alu(f3, inst.r_fmt.funct7[5], 1'b1);
                dec.reg_write = (f3 != 3'b011);  // sltu not supported
            end
            opc_load:
            begin
                dec.imm = i_imm; dec.use_imm = 1'b1;
                dec.is_load       = (f3 == 3'b000) || (f3 == 3'b010) || (f3 == 3'b100);
                dec.reg_write     = dec.is_load;
                dec.load_unsigned = f3[2];
            end
            opc_store:
            begin
                dec.imm = s_imm; dec.use_imm = 1'b1;
                dec.is_store = (f3 == 3'b000) || (f3 == 3'b010); // sb, sw
            end
            opc_branch:
            begin
                dec.imm       = b_imm;
                dec.is_branch = (f3 == 3'b000) || (f3 == 3'b001) || (f3 == 3'b100) || (f3 == 3'b101);
            end
            opc_jal:
            begin
                dec.imm = j_imm; dec.is_jal = 1'b1; dec.reg_write = 1'b1;
            end
            default: ;
        endcase
        if (dec.rd == '0)
            dec.reg_write = 1'b0;          // x0 never written
    end

endmodule

// File: reg_file.sv
// ####################
// 32 x 32 register file, x0 hardwired to zero
// ####################
`timescale 1ns/1ns
module reg_file (
    input  logic                                 clk_in,
    input  logic                                 rst_in,
    input  logic                                 rdy_in,
    input  logic [rv32_core_pkg::reg_addr_w-1:0] rs1,
    input  logic [rv32_core_pkg::reg_addr_w-1:0] rs2,
    output logic [rv32_core_pkg::xlen-1:0]       rs1_data,
    output logic [rv32_core_pkg::xlen-1:0]       rs2_data,
    input  logic                                 we,
    input  logic [rv32_core_pkg::reg_addr_w-1:0] rd,
    input  logic [rv32_core_pkg::xlen-1:0]       wdata
);
    import rv32_core_pkg::*;

    logic [xlen-1:0] regs [0:31];

    assign rs1_data = (rs1 == '0) ? '0 : regs[rs1]; // async read ports
    assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];

    always_ff @(posedge clk_in)
    begin
        if (rst_in)
        begin
            for (int i = 0; i < 32; i++)
                regs[i] <= '0;
        end
        else if (rdy_in && we && rd != '0)   // frozen when rdy low
            regs[rd] <= wdata;
    end

endmodule

// File: alu_exec.sv
// ####################
// alu, branch compare and target adder
// ####################
`timescale 1ns/1ns
module alu_exec (
    input  rv32_core_pkg::dec_t            dec,
    input  logic [rv32_core_pkg::xlen-1:0] rs1_data,
    input  logic [rv32_core_pkg::xlen-1:0] rs2_data,
    input  logic [rv32_core_pkg::xlen-1:0] pc,
    output rv32_core_pkg::exec_t           ex
);
    import rv32_core_pkg::*;

    logic [xlen-1:0] op_a, op_b;
    logic [4:0]      shamt;
    logic            eq, lt, cond;

    assign op_a  = rs1_data;
    assign op_b  = dec.use_imm ? dec.imm : rs2_data;
    assign shamt = op_b[4:0];                         // low 5 bits only
    assign eq    = (rs1_data == rs2_data);
    assign lt    = ($signed(rs1_data) < $signed(rs2_data));

    always_comb
    begin
        case (dec.alu_op)
            ALU_ADD:    ex.alu_result = op_a + op_b;
            ALU_SUB:    ex.alu_result = op_a - op_b;
            ALU_SLL:    ex.alu_result = op_a << shamt;
            ALU_SLT:    ex.alu_result = {31'b0, $signed(op_a) < $signed(op_b)};
            ALU_XOR:    ex.alu_result = op_a ^ op_b;
            ALU_SRL:    ex.alu_result = op_a >> shamt;
            ALU_SRA:    ex.alu_result = $unsigned($signed(op_a) >>> shamt);
            ALU_OR:     ex.alu_result = op_a | op_b;
            ALU_AND:    ex.alu_result = op_a & op_b;
            ALU_PASS_B: ex.alu_result = op_b;         // lui
            default:    ex.alu_result = op_a + op_b;
        endcase
        ex.take_branch = dec.is_jal || (dec.is_branch && cond);
        ex.target      = pc + dec.imm;                // branch and jal share it
    end

    always_comb
    begin
        case (dec.branch_funct)
            3'b000:  cond = eq;     // beq
            3'b001:  cond = !eq;    // bne
            3'b100:  cond = lt;     // blt
            3'b101:  cond = !lt;    // bge
            default: cond = 1'b0;
        endcase
    end

endmodule

// File: mem_seq.sv
// ####################
// byte serial memory engine: fetch, load, store
// ####################
`timescale 1ns/1ns
module mem_seq (
    input  logic                           clk_in,
    input  logic                           rst_in,
    input  logic                           rdy_in,
    input  logic                           start,
    input  logic [1:0]                     kind,
    input  logic [rv32_core_pkg::xlen-1:0] addr,
    input  logic [rv32_core_pkg::xlen-1:0] wdata,
    input  rv32_core_pkg::mem_size_t       size,
    input  logic                           load_unsigned,
    output logic                           done,
    output logic [rv32_core_pkg::xlen-1:0] rdata,
    input  logic [7:0]                     mem_din,
    output logic [7:0]                     mem_dout,
    output logic [rv32_core_pkg::xlen-1:0] mem_a,
    output logic                           mem_wr
);
    import rv32_core_pkg::*;

    logic            busy;
    logic [1:0]      kind_q;
    logic            word_q;       // 4 bytes, fetch or word access
    logic            uns_q;
    logic [2:0]      cnt;          // cycles since the first address
    logic [2:0]      last;
    logic            is_store;
    logic [xlen-1:0] sbuf;         // read collect / store shift

    assign last     = word_q ? 3'd4 : 3'd1;
    assign is_store = (kind_q == kind_store);
    // read ends when the last byte shows on mem_din, store on its last write cycle
    assign done     = busy && (is_store ? (cnt == last - 3'd1) : (cnt == last));

    always_comb
    begin
        if (word_q)
            rdata = {mem_din, sbuf[31:8]};         // little endian, last byte live
        else if (uns_q)
            rdata = {24'b0, mem_din};              // lbu
        else
            rdata = {{24{mem_din[7]}}, mem_din};   // lb
    end

    always_ff @(posedge clk_in)
    begin
        if (rst_in)
        begin
            busy     <= 1'b0;
            cnt      <= '0;
            mem_a    <= '0;
            mem_wr   <= 1'b0;
            mem_dout <= '0;
        end
        else if (rdy_in)                           // everything holds when low
        begin
            if (!busy)
            begin
                if (start)
                begin
                    busy     <= 1'b1;
                    kind_q   <= kind;
                    word_q   <= (kind == kind_fetch) || (size == MEM_WORD);
                    uns_q    <= load_unsigned;
                    cnt      <= '0;
                    mem_a    <= addr;
                    mem_wr   <= (kind == kind_store);
                    mem_dout <= wdata[7:0];        // byte 0 first
                    sbuf     <= wdata;
                end
            end
            else if (done)
            begin
                busy   <= 1'b0;
                mem_wr <= 1'b0;                    // mem_a stays on last byte
            end
            else
            begin
                cnt <= cnt + 3'd1;
                if (cnt < last - 3'd1)
                    mem_a <= mem_a + 32'd1;
                if (is_store)
                begin
                    mem_dout <= sbuf[15:8];        // next store byte
                    sbuf     <= sbuf >> 8;
                end
                else if (cnt != '0)
                    sbuf <= {mem_din, sbuf[31:8]}; // byte from last cycle's address
            end
        end
    end

endmodule

// File: core_ctrl.sv
// ####################
// step fsm, pc, instruction register, write back select
// ####################
`timescale 1ns/1ns
module core_ctrl (
    input  logic                                 clk_in,
    input  logic                                 rst_in,
    input  logic                                 rdy_in,
    input  rv32_core_pkg::dec_t                  dec,
    input  rv32_core_pkg::exec_t                 ex,
    input  logic [rv32_core_pkg::xlen-1:0]       rs2_data,
    output rv32_core_pkg::inst_word_u            inst,
    output logic [rv32_core_pkg::xlen-1:0]       pc,
    output logic                                 mem_start,
    output logic [1:0]                           mem_kind,
    output logic [rv32_core_pkg::xlen-1:0]       mem_addr,
    output logic [rv32_core_pkg::xlen-1:0]       mem_wdata,
    input  logic                                 mem_done,
    input  logic [rv32_core_pkg::xlen-1:0]       mem_rdata,
    output logic                                 rf_we,
    output logic [rv32_core_pkg::reg_addr_w-1:0] rf_rd,
    output logic [rv32_core_pkg::xlen-1:0]       rf_wdata
);
    import rv32_core_pkg::*;

    seq_state_t      state;
    logic            waiting;      // request out, done not yet seen
    logic [xlen-1:0] load_q;
    logic [xlen-1:0] pc_plus4;

    assign pc_plus4  = pc + 32'd4;
    assign mem_start = ((state == S_FETCH) || (state == S_MEM)) && !waiting;
    assign mem_kind  = (state == S_FETCH) ? kind_fetch : (dec.is_load ? kind_load : kind_store);
    assign mem_addr  = (state == S_FETCH) ? pc : ex.alu_result; // effective address
    assign mem_wdata = rs2_data;

    assign rf_we = (state == S_WB) && dec.reg_write;
    assign rf_rd = dec.rd;

    always_comb
    begin
        if (dec.is_load)
            rf_wdata = load_q;
        else if (dec.is_jal)
            rf_wdata = pc_plus4;   // link
        else
            rf_wdata = ex.alu_result;
    end

    always_ff @(posedge clk_in)
    begin
        if (rst_in)
        begin
            state   <= S_FETCH;
            pc      <= reset_pc;
            waiting <= 1'b0;
            inst    <= '0;         // decodes as no-op
        end
        else if (rdy_in)
        begin
            if (mem_start)
                waiting <= 1'b1;
            else if (mem_done)
                waiting <= 1'b0;
            case (state)
                S_FETCH:
                    if (mem_done)
                    begin
                        inst  <= mem_rdata;
                        state <= S_DECODE;
                    end
                S_DECODE: state <= S_EXEC;
                S_EXEC:   state <= (dec.is_load || dec.is_store) ? S_MEM : S_WB;
                S_MEM:
                    if (mem_done)
                    begin
                        load_q <= mem_rdata; // ignored after a store
                        state  <= S_WB;
                    end
                S_WB:
                begin
                    pc    <= ex.take_branch ? ex.target : pc_plus4;
                    state <= S_FETCH;
                end
                default: state <= S_FETCH;
            endcase
        end
    end

endmodule

// File: rv32_core.sv
// ####################
// rv32i multi cycle core top
// ####################
`timescale 1ns/1ns
module rv32_core (
    input  logic                           clk_in,
    input  logic                           rst_in,
    input  logic                           rdy_in,   // freeze when low
    input  logic [7:0]                     mem_din,
    output logic [7:0]                     mem_dout,
    output logic [rv32_core_pkg::xlen-1:0] mem_a,
    output logic                           mem_wr    // 1 for write
);
    import rv32_core_pkg::*;

    inst_word_u            inst;
    dec_t                  dec;
    exec_t                 ex;
    logic [xlen-1:0]       pc, rs1_data, rs2_data;
    logic                  mem_start, mem_done;
    logic [1:0]            mem_kind;
    logic [xlen-1:0]       mem_addr, mem_wdata, mem_rdata;
    logic                  rf_we;
    logic [reg_addr_w-1:0] rf_rd;
    logic [xlen-1:0]       rf_wdata;

    core_ctrl u_ctrl (
        .clk_in, .rst_in, .rdy_in, .dec, .ex, .rs2_data, .inst, .pc,
        .mem_start, .mem_kind, .mem_addr, .mem_wdata, .mem_done, .mem_rdata,
        .rf_we, .rf_rd, .rf_wdata
    );

    mem_seq u_mem (
        .clk_in, .rst_in, .rdy_in, .start(mem_start), .kind(mem_kind),
        .addr(mem_addr), .wdata(mem_wdata), .size(dec.mem_size),
        .load_unsigned(dec.load_unsigned), .done(mem_done), .rdata(mem_rdata),
        .mem_din, .mem_dout, .mem_a, .mem_wr
    );

    inst_decoder u_dec (.inst, .dec);

    reg_file u_rf (
        .clk_in, .rst_in, .rdy_in, .rs1(dec.rs1), .rs2(dec.rs2), .rs1_data, .rs2_data,
        .we(rf_we), .rd(rf_rd), .wdata(rf_wdata)
    );

    alu_exec u_alu (.dec, .rs1_data, .rs2_data, .pc, .ex);

endmodule

// File: rv32_core_props.sv
// ####################
// concurrent checks on the core memory pins and register writes
// ####################
`timescale 1ns/1ns
module rv32_core_props (
    input logic                                 clk_in,
    input logic                                 rst_in,
    input logic                                 rdy_in,
    input logic [rv32_core_pkg::xlen-1:0]       mem_a,
    input logic                                 mem_wr,
    input rv32_core_pkg::seq_state_t            state,
    input logic                                 rf_we,
    input logic [rv32_core_pkg::reg_addr_w-1:0] rf_rd
);
    import rv32_core_pkg::*;

    no_write_in_fetch: assert property (@(posedge clk_in) disable iff (rst_in)
        (state == S_FETCH) |-> !mem_wr)
        else $error("memory write while fetching");

    hold_when_frozen: assert property (@(posedge clk_in) disable iff (rst_in)
        !rdy_in |=> ($stable(mem_a) && $stable(mem_wr)))
        else $error("memory pins moved while rdy_in low");

    no_x0_write: assert property (@(posedge clk_in) disable iff (rst_in)
        rf_we |-> (rf_rd != '0))
        else $error("register write aimed at x0");

endmodule

bind rv32_core rv32_core_props u_props (
    .clk_in, .rst_in, .rdy_in, .mem_a, .mem_wr,
    .state(u_ctrl.state), .rf_we(u_ctrl.rf_we), .rf_rd(u_ctrl.rf_rd)
);

// File: tb_rv32_core.sv
// ####################
// testbench: program table, byte memory model, checks, watchdog
// ####################
`timescale 1ns/1ns
module tb_rv32_core;

    localparam int clk_period = 100;
    localparam int max_rows   = 40;
    localparam int op_add = 0, op_sub = 1, op_sll = 2, op_slt = 3, op_xor = 4, op_srl = 5;
    localparam int op_and = 6, op_or = 7, op_addi = 8, op_slti = 9, op_xori = 10;
    localparam int op_ori = 11, op_andi = 12, op_slli = 13, op_srli = 14, op_srai = 15;
    localparam int op_mov = 16, op_swlw = 17, op_sblb = 18, op_sblbu = 19, op_beq = 20;
    localparam int op_bne = 21, op_blt = 22, op_bge = 23, op_jal = 24;

    logic        clk_in, rst_in, rdy_in, mem_wr;
    logic [7:0]  mem_din, mem_dout;
    logic [31:0] mem_a;
    logic [7:0]  mem [0:65535];                    // 64 KB byte memory
    int          tbl_op [max_rows];
    logic [31:0] tbl_a [max_rows], tbl_b [max_rows], tbl_exp [max_rows];
    int          n_rows, errors, seed;
    bit          table_ready, pulse_rdy, stored;
    logic [31:0] result_word;

    rv32_core UUT (.clk_in, .rst_in, .rdy_in, .mem_din, .mem_dout, .mem_a, .mem_wr);

    initial
    begin
        clk_in = 1'b0;
        forever #(clk_period / 2) clk_in = ~clk_in;
    end

    // read data shows up one cycle after the address, writes commit on the edge
    always @(posedge clk_in)
    begin
        logic [15:0] a_s;
        logic        wr_s, go;
        logic [7:0]  d_s;
        a_s  = mem_a[15:0];
        wr_s = mem_wr;
        d_s  = mem_dout;
        go   = rdy_in;
        #10;
        if (go)
        begin
            if (wr_s)
            begin
                mem[a_s] = d_s;
                if (a_s[15:2] == 14'h0040)        // result word at 0x100
                begin
                    result_word[8*a_s[1:0] +: 8] = d_s;
                    if (a_s[1:0] == 2'd3)
                        stored = 1'b1;
                end
            end
            mem_din = mem[a_s];
        end
    end

    always @(posedge clk_in)                      // random freeze cycles
    begin
        #10;
        rdy_in = pulse_rdy ? (($random(seed) & 3) != 0) : 1'b1;
    end

    // expected value straight from the RV32I rules
    function automatic logic [31:0] ref_result(input int op, input logic [31:0] a, b);
        case (op)
            op_add:  ref_result = a + b;
            op_sub:  ref_result = a - b;
            op_sll:  ref_result = a << b[4:0];
            op_slt:  ref_result = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            op_xor:  ref_result = a ^ b;
            op_srl:  ref_result = a >> b[4:0];
            op_and:  ref_result = a & b;
            op_or:   ref_result = a | b;
            default: ref_result = 32'd0;
        endcase
    endfunction

    function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd,
                                          input logic [6:0] opc);
        enc_i = {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
                                          input logic [2:0] f3);
        enc_s = {imm[11:5], rs2, 5'd0, f3, imm[4:0], 7'h23};   // base x0
    endfunction

    function automatic logic [2:0] op_funct3(input int op);
        case (op)
            op_sll, op_slli, op_bne: op_funct3 = 3'b001;
            op_slt, op_slti:         op_funct3 = 3'b010;
            op_xor, op_xori, op_blt: op_funct3 = 3'b100;
            op_srl, op_srli, op_srai, op_bge: op_funct3 = 3'b101;
            op_or, op_ori:           op_funct3 = 3'b110;
            op_and, op_andi:         op_funct3 = 3'b111;
            default:                 op_funct3 = 3'b000;
        endcase
    endfunction

    task automatic put_word(input logic [15:0] addr, input logic [31:0] w);
        for (int k = 0; k < 4; k++)
            mem[addr + k] = w[8*k +: 8];          // little endian
    endtask

    task automatic load_const(input logic [15:0] addr, input logic [4:0] rd,
                              input logic [31:0] v);
        logic [31:0] hi;
        hi = v + 32'h800;                         // round for the signed addi
        put_word(addr, {hi[31:12], rd, 7'h37});
        put_word(addr + 4, enc_i(v[11:0], rd, 3'b000, rd, 7'h13));
    endtask

    task automatic load_program(input int op, input logic [31:0] a, b);
        logic [15:0] pc;
        logic [2:0]  f3;
        for (int i = 0; i < 65536; i++)
            mem[i] = i[7:0] ^ i[15:8];            // fill from the whole address
        for (int i = 16'h200; i < 16'h204; i++)
            mem[i] = 8'h80;
        load_const(16'h0, 5'd1, a);
        load_const(16'h8, 5'd2, b);
        pc = 16'h10;
        f3 = op_funct3(op);
        if (op <= op_or)
            put_word(pc, {(op == op_sub) ? 7'h20 : 7'h00, 5'd2, 5'd1, f3, 5'd3, 7'h33});
        else if (op == op_slli || op == op_srli || op == op_srai)
            put_word(pc, enc_i({(op == op_srai) ? 7'h20 : 7'h00, b[4:0]}, 5'd1, f3, 5'd3, 7'h13));
        else if (op <= op_andi)
            put_word(pc, enc_i(b[11:0], 5'd1, f3, 5'd3, 7'h13));
        else if (op == op_mov)
            put_word(pc, enc_i(12'd0, 5'd1, 3'b000, 5'd3, 7'h13));
        else if (op >= op_swlw && op <= op_sblbu)
        begin
            put_word(pc, enc_s(12'h200, 5'd1, (op == op_swlw) ? 3'b010 : 3'b000));
            pc += 4;
            f3 = (op == op_swlw) ? 3'b010 : ((op == op_sblbu) ? 3'b100 : 3'b000);
            put_word(pc, enc_i(12'h200, 5'd0, f3, 5'd3, 7'h03));
        end
        else if (op == op_jal)
        begin
            put_word(pc, {1'b0, 10'd4, 1'b0, 8'd0, 5'd3, 7'h6f});  // jal x3, +8
            pc += 4;
            put_word(pc, enc_i(12'd0, 5'd0, 3'b000, 5'd3, 7'h13)); // skipped
        end
        else
        begin
            put_word(pc, enc_i(12'd1, 5'd0, 3'b000, 5'd3, 7'h13)); // flag = 1
            pc += 4;
            put_word(pc, {1'b0, 6'd0, 5'd2, 5'd1, f3, 4'd4, 1'b0, 7'h63}); // +8
            pc += 4;
            put_word(pc, enc_i(12'd2, 5'd0, 3'b000, 5'd3, 7'h13)); // flag = 2
        end
        pc += 4;
        put_word(pc, enc_s(12'h100, 5'd3, 3'b010));                // sw x3, 0x100
        put_word(pc + 4, 32'h0000_006f);                           // jal x0, 0
    endtask

    task automatic add_row(input int op, input logic [31:0] a, b, exp);
        tbl_op[n_rows]  = op;
        tbl_a[n_rows]   = a;
        tbl_b[n_rows]   = b;
        tbl_exp[n_rows] = exp;
        n_rows++;
    endtask

    task automatic run_reset;
        pulse_rdy = 1'b0;
        stored    = 1'b0;
        @(posedge clk_in);
        #10;
        rst_in = 1'b1;
        repeat (5) @(posedge clk_in);
        #10;
        rst_in = 1'b0;
    endtask

    initial
    begin
        logic [31:0] ra, rb;
        int          rop;
        rst_in = 1'b1;
        rdy_in = 1'b1;
        mem_din = 8'h00;
        seed = 16201;
        errors = 0;
        n_rows = 0;
        add_row(op_add, 32'd5, 32'd7, 32'h0000_000C);
        add_row(op_sub, 32'd3, 32'd10, 32'hFFFF_FFF9);
        add_row(op_slt, 32'hFFFF_FFF0, 32'd3, 32'd1);
        add_row(op_slt, 32'd3, 32'hFFFF_FFF0, 32'd0);
        add_row(op_sll, 32'd1, 32'd31, 32'h8000_0000);
        add_row(op_srl, 32'h8000_0000, 32'd4, 32'h0800_0000);
        add_row(op_and, 32'hF0F0_F0F0, 32'hFF00_FF00, 32'hF000_F000);
        add_row(op_or, 32'hF0F0_F0F0, 32'hFF00_FF00, 32'hFFF0_FFF0);
        add_row(op_xor, 32'hF0F0_F0F0, 32'hFF00_FF00, 32'h0FF0_0FF0);
        add_row(op_addi, 32'd100, 32'h0000_0FFF, 32'h0000_0063);
        add_row(op_slti, 32'hFFFF_FFFB, 32'd1, 32'd1);
        add_row(op_xori, 32'h0000_00FF, 32'h0000_0800, 32'hFFFF_F8FF);
        add_row(op_ori, 32'h1200_0000, 32'h0000_0034, 32'h1200_0034);
        add_row(op_andi, 32'h1234_5678, 32'h0000_0F0F, 32'h1234_5608);
        add_row(op_slli, 32'd3, 32'd4, 32'h0000_0030);
        add_row(op_srli, 32'hF000_0000, 32'd28, 32'h0000_000F);
        add_row(op_srai, 32'hF000_0000, 32'd28, 32'hFFFF_FFFF);
        add_row(op_mov, 32'hDEAD_BEEF, 32'd0, 32'hDEAD_BEEF);      // negative addi imm
        add_row(op_mov, 32'h7FFF_F800, 32'd0, 32'h7FFF_F800);
        add_row(op_swlw, 32'hCAFE_F00D, 32'd0, 32'hCAFE_F00D);
        add_row(op_sblb, 32'h1234_56F5, 32'd0, 32'hFFFF_FFF5);     // byte differs from 0x80
        add_row(op_sblbu, 32'h1234_56F5, 32'd0, 32'h0000_00F5);
        add_row(op_beq, 32'd5, 32'd5, 32'd1);
        add_row(op_beq, 32'd5, 32'd6, 32'd2);
        add_row(op_bne, 32'd5, 32'd6, 32'd1);
        add_row(op_bne, 32'd5, 32'd5, 32'd2);
        add_row(op_blt, 32'hFFFF_FFFF, 32'd1, 32'd1);
        add_row(op_blt, 32'd1, 32'hFFFF_FFFF, 32'd2);
        add_row(op_bge, 32'd1, 32'hFFFF_FFFF, 32'd1);
        add_row(op_bge, 32'hFFFF_FFFE, 32'hFFFF_FFFF, 32'd2);
        add_row(op_jal, 32'd0, 32'd0, 32'h0000_0014);
        for (int i = 0; i < 8; i++)
        begin
            rop = op_add + i;                      // each r-type op once
            ra  = $random(seed);
            rb  = $random(seed);
            add_row(rop, ra, rb, ref_result(rop, ra, rb));
        end
        table_ready = 1'b1;
        for (int r = 0; r < n_rows; r++)
        begin
            load_program(tbl_op[r], tbl_a[r], tbl_b[r]);
            run_reset();
            @(posedge clk_in);
            #20;                                   // first access after reset
            if (mem_a !== 32'd0 || mem_wr !== 1'b0)
            begin
                $display("MISMATCH time=%0t signal=mem_a/mem_wr expected=0/0 actual=%h/%b",
                         $time, mem_a, mem_wr);
                errors++;
            end
            pulse_rdy = r[0];                      // odd rows run with freezes
            while (!stored)
                @(posedge clk_in);
            #20;
            if (result_word !== tbl_exp[r])
            begin
                $display("MISMATCH time=%0t signal=mem[0x100] row=%0d expected=%h actual=%h",
                         $time, r, tbl_exp[r], result_word);
                errors++;
            end
        end
        $display("rows=%0d errors=%0d", n_rows, errors);
        if (errors == 0)
            $display("TESTS PASSED");
        else
            $display("TESTS FAILED");
        $finish;
    end

    initial
    begin
        wait (table_ready);
        #(n_rows * 200 * clk_period);
        $display("watchdog expired before all rows stored their result, errors=%0d", errors);
        $display("TESTS FAILED");
        $finish;
    end

endmodule

// File: rv32_core.f
rv32_core_pkg.sv
inst_decoder.sv
reg_file.sv
alu_exec.sv
mem_seq.sv
core_ctrl.sv
rv32_core.sv
rv32_core_props.sv
tb_rv32_core.sv

// File: Makefile
TOP = tb_rv32_core
LOG = sim.log

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f rv32_core.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f rv32_core.f --top-module $(TOP) -o V$(TOP)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "TESTS PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
